// ==== verilog/simd_issue_defs.svh ====
// SIMD issue shared constants
// Vector length, latency limits and tag width for the issue-side bookkeeping

`ifndef SIMD_ISSUE_DEFS_SVH
`define SIMD_ISSUE_DEFS_SVH

// Vector register length in bits
`define SIMD_VLEN       128

// Cycles of a full DIV/REM, also the depth of the write-back wheel
`define SIMD_DIV_LAT    32

// log2 of VLEN in bytes, reduction latency is derived from it
`define SIMD_RED_BASE   4

// Instruction tag width
`define SIMD_TAG_W      4

`endif

// ==== verilog/simd_issue_pkg.sv ====
// SIMD issue types
// Operation and SEW encodings plus the structs passed between the issue blocks

`include "simd_issue_defs.svh"

package simd_issue_pkg;

    typedef logic [`SIMD_TAG_W-1:0] simd_tag_t;
    typedef logic [`SIMD_VLEN-1:0]  vreg_t;
    typedef logic [63:0]            xreg_t;
    typedef logic [5:0]             simd_lat_t;   // Up to SIMD_DIV_LAT cycles

    // Encodings 13..31 are spare
    typedef enum logic [4:0] {
        VADD    = 5'd0,
        VMUL    = 5'd1,
        VMULH   = 5'd2,
        VWMUL   = 5'd3,
        VMACC   = 5'd4,
        VNMSAC  = 5'd5,
        VSMUL   = 5'd6,
        VREDSUM = 5'd7,
        VREDMAX = 5'd8,
        VDIV    = 5'd9,
        VDIVU   = 5'd10,
        VREM    = 5'd11,
        VREMU   = 5'd12
    } simd_op_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

    // Instruction as seen by the issue logic, about 330 bits
    typedef struct packed {
        simd_tag_t tag;
        simd_op_t  op;
        sew_t      sew;
        logic      is_opvx;   // Scalar rs1 replaces vs1
        vreg_t     vs1;
        vreg_t     vs2;
        xreg_t     rs1;
    } simd_instr_t;

    typedef struct packed {
        simd_tag_t tag;
        simd_lat_t lat;
    } simd_issue_t;

    typedef struct packed {
        simd_tag_t tag;
        simd_lat_t lat;
    } simd_wb_t;

endpackage

// ==== verilog/simd_intake_buffer.sv ====
// SIMD intake buffer
// Four-phase req/ack receiver with a single pending instruction entry
`timescale 1ns/1ps

module simd_intake_buffer import simd_issue_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        flush_i,
    input  logic        req_i,
    input  simd_instr_t instr_i,
    output logic        ack_o,
    input  logic        issue_i,
    output logic        pend_valid_o,
    output simd_instr_t pend_instr_o
);

    typedef enum logic [1:0] {
        S_IDLE,      // Ack low, ready for a request
        S_ACK,       // Captured, ack high until req drops
        S_WAIT_LOW   // Flushed while acked, no second capture of the same req
    } state_t;

    state_t      state_q, state_d;
    logic        capture;
    logic        pend_valid_q;
    simd_instr_t pend_instr_q;

    always_comb begin
        state_d = state_q;
        capture = 1'b0;
        case (state_q)
            S_IDLE: begin
                // Capture only into a free entry
                if (req_i && !pend_valid_q && !flush_i) begin
                    capture = 1'b1;
                    state_d = S_ACK;
                end
            end
            S_ACK: begin
                if (!req_i) state_d = S_IDLE;
                else if (flush_i) state_d = S_WAIT_LOW;
            end
            S_WAIT_LOW: begin
                if (!req_i) state_d = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= S_IDLE;
            pend_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (flush_i) pend_valid_q <= 1'b0;
            else if (capture) pend_valid_q <= 1'b1;
            else if (issue_i) pend_valid_q <= 1'b0;   // Entry leaves on issue
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) pend_instr_q <= instr_i;
    end

    assign ack_o        = (state_q == S_ACK);
    assign pend_valid_o = pend_valid_q;
    assign pend_instr_o = pend_instr_q;

endmodule

// ==== verilog/simd_scoreboard.sv ====
// SIMD scoreboard
// Latency lookup, division reuse tracking and the issue/stall decision
`timescale 1ns/1ps

`include "simd_issue_defs.svh"

module simd_scoreboard import simd_issue_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     flush_i,
    input  logic                     pend_valid_i,
    input  simd_instr_t              pend_instr_i,
    input  logic [`SIMD_DIV_LAT-1:0] slot_busy_i,
    output logic                     issue_o,
    output simd_issue_t              issue_info_o
);

    localparam int IDX_W = $clog2(`SIMD_DIV_LAT);

    logic      is_mul;
    logic      is_mac;
    logic      is_red;
    logic      is_div;
    logic      is_sdiv;       // Signed pair VDIV/VREM
    logic      div_reuse;
    logic      slot_stall;
    logic      div_stall;
    simd_lat_t lat;

    // Last issued division
    logic      prev_valid_q;
    logic      prev_opvx_q;
    logic      prev_signed_q;
    vreg_t     prev_vs1_q;
    vreg_t     prev_vs2_q;
    xreg_t     prev_rs1_q;

    simd_lat_t div_cnt_q;     // Cycles left until the long division writes back

    // Operation classes
    assign is_mul  = pend_instr_i.op inside {VMUL, VMULH, VWMUL};
    assign is_mac  = pend_instr_i.op inside {VMACC, VNMSAC, VSMUL};
    assign is_red  = pend_instr_i.op inside {VREDSUM, VREDMAX};
    assign is_div  = pend_instr_i.op inside {VDIV, VDIVU, VREM, VREMU};
    assign is_sdiv = pend_instr_i.op inside {VDIV, VREM};

    // Result already known when operands and signedness repeat
    assign div_reuse = prev_valid_q
                    && (prev_opvx_q == pend_instr_i.is_opvx)
                    && (prev_signed_q == is_sdiv)
                    && (prev_vs2_q == pend_instr_i.vs2)
                    && (pend_instr_i.is_opvx ? (prev_rs1_q == pend_instr_i.rs1)
                                             : (prev_vs1_q == pend_instr_i.vs1));

    always_comb begin
        if (is_mul) begin
            lat = (pend_instr_i.sew == SEW_64) ? 6'd3 : 6'd2;
        end else if (is_mac) begin
            lat = (pend_instr_i.sew == SEW_64) ? 6'd4 : 6'd3;
        end else if (is_red) begin
            // Tree depth shrinks as elements get wider
            case (pend_instr_i.sew)
                SEW_32:  lat = 6'(`SIMD_RED_BASE);
                SEW_64:  lat = 6'(`SIMD_RED_BASE - 1);
                default: lat = 6'(`SIMD_RED_BASE + 1);
            endcase
        end else if (is_div) begin
            lat = div_reuse ? 6'd1 : 6'(`SIMD_DIV_LAT);
        end else begin
            lat = 6'd1;
        end
    end

    // Write-back port already claimed for our completion cycle
    assign slot_stall = slot_busy_i[IDX_W'(lat - 6'd1)];
    assign div_stall  = is_div && (div_cnt_q != '0);   // One divider only

    assign issue_o      = pend_valid_i && !slot_stall && !div_stall && !flush_i;
    assign issue_info_o = '{tag: pend_instr_i.tag, lat: lat};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            div_cnt_q    <= '0;
            prev_valid_q <= 1'b0;
        end else if (flush_i) begin
            div_cnt_q    <= '0;
            prev_valid_q <= 1'b0;   // A flushed division never produced its result
        end else begin
            if (issue_o && is_div && !div_reuse) begin
                div_cnt_q <= 6'(`SIMD_DIV_LAT - 1);
            end else if (div_cnt_q != '0) begin
                div_cnt_q <= div_cnt_q - 6'd1;
            end
            if (issue_o && is_div) prev_valid_q <= 1'b1;
        end
    end

    // Operands of the last division, kept for the reuse compare
    always_ff @(posedge clk_i) begin
        if (issue_o && is_div) begin
            prev_opvx_q   <= pend_instr_i.is_opvx;
            prev_signed_q <= is_sdiv;
            prev_vs1_q    <= pend_instr_i.vs1;
            prev_vs2_q    <= pend_instr_i.vs2;
            prev_rs1_q    <= pend_instr_i.rs1;
        end
    end

endmodule

// ==== verilog/simd_wb_sequencer.sv ====
// SIMD write-back sequencer
// Timing wheel that presents each issued tag on its completion cycle
`timescale 1ns/1ps

`include "simd_issue_defs.svh"

module simd_wb_sequencer import simd_issue_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     flush_i,
    input  logic                     issue_i,
    input  simd_issue_t              issue_info_i,
    output logic [`SIMD_DIV_LAT-1:0] slot_busy_o,
    output logic                     wb_valid_o,
    output simd_wb_t                 wb_o
);

    localparam int SLOTS = `SIMD_DIV_LAT;
    localparam int IDX_W = $clog2(SLOTS);

    logic [SLOTS-1:0] valid_q, valid_d;
    simd_wb_t         slot_q [SLOTS];
    simd_wb_t         slot_d [SLOTS];
    logic [IDX_W-1:0] wr_idx;

    // Slot L-1 after the shift reaches slot 0 exactly L cycles from issue
    assign wr_idx = IDX_W'(issue_info_i.lat - 6'd1);

    always_comb begin
        valid_d = {1'b0, valid_q[SLOTS-1:1]};   // Advance one slot
        for (int k = 0; k < SLOTS - 1; k++) begin
            slot_d[k] = slot_q[k + 1];
        end
        slot_d[SLOTS-1] = slot_q[SLOTS-1];
        if (issue_i) begin
            valid_d[wr_idx] = 1'b1;
            slot_d[wr_idx]  = '{tag: issue_info_i.tag, lat: issue_info_i.lat};
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;   // Drop every pending write-back
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < SLOTS; k++) begin
            slot_q[k] <= slot_d[k];
        end
    end

    // Occupancy after this cycle's shift, bit k is slot k next cycle
    assign slot_busy_o = {1'b0, valid_q[SLOTS-1:1]};
    assign wb_valid_o  = valid_q[0];
    assign wb_o        = slot_q[0];

endmodule

// ==== verilog/simd_issue_top.sv ====
// SIMD issue top
// Intake buffer, scoreboard and write-back sequencer of the vector unit
`timescale 1ns/1ps

`include "simd_issue_defs.svh"

module simd_issue_top import simd_issue_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        flush_i,
    input  logic        req_i,
    input  simd_instr_t instr_i,
    output logic        ack_o,
    output logic        wb_valid_o,
    output simd_wb_t    wb_o
);

    logic                     pend_valid;
    simd_instr_t              pend_instr;
    logic                     issue;
    simd_issue_t              issue_info;
    logic [`SIMD_DIV_LAT-1:0] slot_busy;

    simd_intake_buffer u_intake (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .req_i        (req_i),
        .instr_i      (instr_i),
        .ack_o        (ack_o),
        .issue_i      (issue),
        .pend_valid_o (pend_valid),
        .pend_instr_o (pend_instr)
    );

    simd_scoreboard u_scoreboard (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .pend_valid_i (pend_valid),
        .pend_instr_i (pend_instr),
        .slot_busy_i  (slot_busy),
        .issue_o      (issue),
        .issue_info_o (issue_info)
    );

    simd_wb_sequencer u_wb_seq (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .issue_i      (issue),
        .issue_info_i (issue_info),
        .slot_busy_o  (slot_busy),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o)
    );

endmodule

// ==== bench/simd_issue_props.sv ====
// SIMD issue properties
// Handshake and write-back timing checks bound into the issue top
`timescale 1ns/1ps

module simd_issue_props import simd_issue_pkg::*; (
    input logic        clk_i,
    input logic        rstn_i,
    input logic        flush_i,
    input logic        req_i,
    input logic        ack_o,
    input logic        wb_valid_o,
    input simd_wb_t    wb_o,
    input logic        issue_i,
    input simd_issue_t issue_info_i
);

    int          cyc;
    int          due [16];     // Expected write-back cycle per tag
    logic [15:0] armed;        // Tag issued and not yet written back
    logic        overdue;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cyc   <= 0;
            armed <= '0;
        end else begin
            cyc <= cyc + 1;
            if (flush_i) begin
                armed <= '0;
            end else begin
                if (wb_valid_o) armed[wb_o.tag] <= 1'b0;
                if (issue_i) begin
                    armed[issue_info_i.tag] <= 1'b1;
                    due[issue_info_i.tag]   <= cyc + int'(issue_info_i.lat);
                end
            end
        end
    end

    always_comb begin
        overdue = 1'b0;
        for (int t = 0; t < 16; t++) begin
            if (armed[t] && due[t] < cyc) overdue = 1'b1;
        end
    end

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(ack_o) |-> $past(req_i)) else $error("ack_o rose without req_i");

    req_holds: assert property (@(posedge clk_i) disable iff (!rstn_i || flush_i)
        req_i && !ack_o |=> req_i) else $error("req_i dropped before ack_o");

    wb_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !wb_valid_o) else $error("wb_valid_o high right after reset");

    // Write-back lands on the issued latency, and none goes missing
    wb_on_time: assert property (@(posedge clk_i) disable iff (!rstn_i || flush_i)
        wb_valid_o |-> armed[wb_o.tag] && due[wb_o.tag] == cyc)
        else $error("write-back tag %h off its completion cycle", wb_o.tag);

    wb_not_lost: assert property (@(posedge clk_i) disable iff (!rstn_i || flush_i)
        !overdue) else $error("issued tag missed its write-back cycle");

endmodule

bind simd_issue_top simd_issue_props u_props (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .flush_i      (flush_i),
    .req_i        (req_i),
    .ack_o        (ack_o),
    .wb_valid_o   (wb_valid_o),
    .wb_o         (wb_o),
    .issue_i      (issue),
    .issue_info_i (issue_info)
);

// ==== bench/tb_simd_issue.sv ====
// SIMD issue testbench
// Directed tests of latency, division reuse and exclusion, collision, back-pressure, flush
`timescale 1ns/1ps

`include "simd_issue_defs.svh"

module tb_simd_issue import simd_issue_pkg::*; ();

    localparam int TIMEOUT = 2000;   // Roughly twice the summed test lengths

    logic        clk_i;
    logic        rstn_i;
    logic        flush_i;
    logic        req_i;
    simd_instr_t instr_i;
    logic        ack_o;
    logic        wb_valid_o;
    simd_wb_t    wb_o;

    int   cyc = 0;
    int   fails = 0;
    int   ntests = 0;
    logic log_clr = 1'b0;
    int   wb_cyc [16];
    int   wb_cnt [16];
    int   wb_seq [16];     // Arrival order of each tag
    int   wb_total = 0;
    simd_lat_t wb_lat [16];   // Latency field presented with each tag

    simd_issue_top u_simd_issue_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Write-back monitor, cycle index is that of the sampled cycle
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (log_clr) begin
            for (int t = 0; t < 16; t++) begin
                wb_cnt[t] <= 0;
            end
        end else if (rstn_i && wb_valid_o) begin
            wb_cyc[wb_o.tag] <= cyc;
            wb_cnt[wb_o.tag] <= wb_cnt[wb_o.tag] + 1;
            wb_seq[wb_o.tag] <= wb_total;
            wb_lat[wb_o.tag] <= wb_o.lat;
            wb_total         <= wb_total + 1;
        end
    end

    // Latency table of the vector unit
    function automatic int ref_lat(simd_op_t op, sew_t sew, bit reuse);
        case (op)
            VMUL, VMULH, VWMUL:       return (sew == SEW_64) ? 3 : 2;
            VMACC, VNMSAC, VSMUL:     return (sew == SEW_64) ? 4 : 3;
            VREDSUM, VREDMAX:         return (sew == SEW_64) ? 3 : (sew == SEW_32) ? 4 : 5;
            VDIV, VDIVU, VREM, VREMU: return reuse ? 1 : `SIMD_DIV_LAT;
            default:                  return 1;
        endcase
    endfunction

    function automatic simd_instr_t rand_instr(simd_tag_t tag, simd_op_t op, sew_t sew);
        simd_instr_t in;
        logic [31:0] r;
        r          = $urandom();
        in.tag     = tag;
        in.op      = op;
        in.sew     = sew;
        in.is_opvx = r[0];
        in.vs1     = {$urandom(), $urandom(), $urandom(), $urandom()};
        in.vs2     = {$urandom(), $urandom(), $urandom(), $urandom()};
        in.rs1     = {$urandom(), $urandom()};
        return in;
    endfunction

    // Four-phase producer that raises req as soon as the previous ack is low
    // The returned ack_cyc is the first cycle with ack_o high
    task automatic send(input simd_instr_t in, output int ack_cyc);
        req_i   <= 1'b1;
        instr_i <= in;
        do @(posedge clk_i); while (!ack_o);
        ack_cyc = cyc;
        req_i <= 1'b0;
        do @(posedge clk_i); while (ack_o);
    endtask

    task automatic wait_wb(input simd_tag_t tag);
        while (wb_cnt[tag] == 0) @(posedge clk_i);
    endtask

    task automatic clear_log();
        log_clr <= 1'b1;
        @(posedge clk_i);
        log_clr <= 1'b0;
    endtask

    task automatic check_lat(input simd_tag_t tag, input int ack_cyc, input int exp);
        int got;
        got = wb_cyc[tag] - ack_cyc;
        assert (wb_cnt[tag] == 1 && got == exp && wb_lat[tag] == exp) else begin
            $display("Error: wb_o.tag %h latency %h wb_o.lat %h count %h, expected latency %h",
                     tag, got, wb_lat[tag], wb_cnt[tag], exp);
            fails++;
        end
    endtask

    task automatic report(input string name, input int f0);
        ntests++;
        $display("%-16s %0d errors", name, fails - f0);
    endtask

    task automatic test_latency();
        simd_op_t    ops [5] = '{VWMUL, VNMSAC, VREDMAX, VDIVU, VADD};
        simd_instr_t in;
        int          a;
        int          f0;
        f0 = fails;
        for (int c = 0; c < 5; c++) begin
            for (int s = 0; s < 4; s++) begin
                in = rand_instr(4'(4 * c + s), ops[c], sew_t'(s[1:0]));
                clear_log();
                send(in, a);
                wait_wb(in.tag);
                check_lat(in.tag, a, ref_lat(in.op, in.sew, 1'b0));
            end
        end
        report("latency", f0);
    endtask

    task automatic test_div_reuse();
        simd_instr_t a_in;
        simd_instr_t b_in;
        simd_instr_t c_in;
        int          a0;
        int          a1;
        int          a2;
        int          f0;
        f0 = fails;
        clear_log();
        a_in     = rand_instr(4'd1, VDIV, SEW_32);
        b_in     = a_in;
        b_in.tag = 4'd2;
        b_in.op  = VREM;             // Same signed pair and operands
        c_in     = b_in;
        c_in.tag = 4'd3;
        c_in.vs2 = ~b_in.vs2;
        send(a_in, a0);
        wait_wb(4'd1);
        send(b_in, a1);
        wait_wb(4'd2);
        send(c_in, a2);
        wait_wb(4'd3);
        check_lat(4'd1, a0, ref_lat(VDIV, SEW_32, 1'b0));
        check_lat(4'd2, a1, ref_lat(VREM, SEW_32, 1'b1));
        check_lat(4'd3, a2, ref_lat(VREM, SEW_32, 1'b0));
        report("div_reuse", f0);
    endtask

    task automatic test_div_excl();
        int a0;
        int a1;
        int a2;
        int f0;
        f0 = fails;
        clear_log();
        send(rand_instr(4'd1, VDIV, SEW_16), a0);
        send(rand_instr(4'd2, VADD, SEW_8), a1);
        send(rand_instr(4'd3, VDIVU, SEW_16), a2);
        wait_wb(4'd3);
        check_lat(4'd1, a0, `SIMD_DIV_LAT);
        check_lat(4'd2, a1, 1);
        assert (wb_cyc[3] - wb_cyc[1] >= `SIMD_DIV_LAT) else begin
            $display("Second division wrote back while the first one was still running");
            fails++;
        end
        report("div_exclusion", f0);
    endtask

    task automatic test_collision();
        int a0;
        int a1;
        int hold;
        int f0;
        f0 = fails;
        clear_log();
        send(rand_instr(4'd1, VREDSUM, SEW_8), a0);
        send(rand_instr(4'd2, VADD, SEW_8), a1);   // Aimed at the reduction's write-back cycle
        wait_wb(4'd1);
        wait_wb(4'd2);
        // The add is held one cycle when its completion cycle is already taken
        hold = (a1 + ref_lat(VADD, SEW_8, 1'b0) == a0 + ref_lat(VREDSUM, SEW_8, 1'b0))
               ? 1 : 0;
        check_lat(4'd1, a0, ref_lat(VREDSUM, SEW_8, 1'b0));
        check_lat(4'd2, a1 + hold, ref_lat(VADD, SEW_8, 1'b0));
        assert (wb_seq[1] < wb_seq[2] && wb_cyc[1] != wb_cyc[2]) else begin
            $display("Write-backs shared a cycle or left issue order");
            fails++;
        end
        report("collision", f0);
    endtask

    task automatic test_backpressure();
        int a0;
        int a1;
        int a2;
        int f0;
        f0 = fails;
        clear_log();
        send(rand_instr(4'd1, VDIV, SEW_64), a0);
        send(rand_instr(4'd2, VREMU, SEW_64), a1);   // Held behind the running division
        send(rand_instr(4'd3, VMUL, SEW_8), a2);
        assert (a2 - a0 > `SIMD_DIV_LAT) else begin
            $display("Next request was acked while a stalled division held the buffer");
            fails++;
        end
        for (int t = 1; t <= 3; t++) begin
            wait_wb(4'(t));
        end
        check_lat(4'd1, a0, `SIMD_DIV_LAT);
        check_lat(4'd3, a2, 2);
        assert (wb_cnt[2] == 1) else begin
            $display("Error: wb_o.tag 2 count %h, expected %h", wb_cnt[2], 1);
            fails++;
        end
        report("backpressure", f0);
    endtask

    task automatic test_flush();
        simd_instr_t a_in;
        simd_instr_t b_in;
        int          a0;
        int          a1;
        int          f0;
        f0 = fails;
        clear_log();
        a_in     = rand_instr(4'd5, VDIV, SEW_8);
        b_in     = a_in;
        b_in.tag = 4'd6;
        send(a_in, a0);
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        send(b_in, a1);   // Reuse state and divider are gone after flush
        wait_wb(4'd6);
        check_lat(4'd6, a1, ref_lat(VDIV, SEW_8, 1'b0));
        assert (wb_cnt[5] == 0) else begin
            $display("Error: wb_o.tag 5 count %h after flush, expected %h", wb_cnt[5], 0);
            fails++;
        end
        report("flush", f0);
    endtask

    initial begin
        while (cyc < TIMEOUT) @(posedge clk_i);
        $display("Timeout after %0d cycles, a handshake or write-back never completed", cyc);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h12c));
        rstn_i  = 1'b0;
        flush_i = 1'b0;
        req_i   = 1'b0;
        instr_i = '0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        test_latency();
        test_div_reuse();
        test_div_excl();
        test_collision();
        test_backpressure();
        test_flush();
        $display("%0d tests, %0d errors", ntests, fails);
        if (fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== simd_issue.f ====
+incdir+verilog
verilog/simd_issue_pkg.sv
verilog/simd_intake_buffer.sv
verilog/simd_scoreboard.sv
verilog/simd_wb_sequencer.sv
verilog/simd_issue_top.sv
bench/simd_issue_props.sv
bench/tb_simd_issue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the SIMD issue testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f simd_issue.f \
    --top-module tb_simd_issue -Mdir obj_dir > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vtb_simd_issue > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench passed" "$SIM_LOG"; then
    exit 0
fi
echo "Simulation did not pass, see $SIM_LOG"
exit 1
